/* verilog/board_pkg.sv */
// board package for the four-axis amplifier control block
// widths, register map, constants and shared types
package board_pkg;

    // ------------------------------
    // widths and scaling
    // ------------------------------
    localparam int num_axes            = 4;
    localparam int wdog_prescale_width = 4;   // one tick per 16 sysclk

    typedef logic [num_axes-1:0] axis_t;       // one bit per axis
    typedef logic [7:0]          reg_addr_t;   // [7:4] channel, [3:0] offset
    typedef logic [31:0]         reg_data_t;
    typedef logic [15:0]         wdog_period_t;
    typedef logic [12:0]         settle_cnt_t; // wide enough for 7680

    // settle ticks, sim value (hardware uses 7680)
    localparam settle_cnt_t mv_settle_ticks = 13'd8;

    // ------------------------------
    // channel 0 register map
    // ------------------------------
    localparam logic [3:0] board_chan      = 4'd0;
    localparam logic [3:0] reg_status      = 4'd0;
    localparam logic [3:0] reg_phyctrl     = 4'd1;
    localparam logic [3:0] reg_phydata     = 4'd2;
    localparam logic [3:0] reg_timeout     = 4'd3;
    localparam logic [3:0] reg_version     = 4'd4;
    localparam logic [3:0] reg_tempsns     = 4'd5;
    localparam logic [3:0] reg_digiout     = 4'd6;
    localparam logic [3:0] reg_fw_version  = 4'd7;
    localparam logic [3:0] reg_promstat    = 4'd8;
    localparam logic [3:0] reg_promres     = 4'd9;
    localparam logic [3:0] reg_digin       = 4'd10;
    localparam logic [3:0] reg_safety      = 4'd11;
    localparam logic [3:0] reg_wdog        = 4'd14;
    localparam logic [3:0] reg_regdisable  = 4'd15;

    localparam reg_data_t board_version = 32'h5445_5354;  // ascii "TEST"
    localparam reg_data_t fw_version    = 32'h0000_0003;

    // synchronized board inputs
    typedef struct packed {
        axis_t neg_limit;
        axis_t pos_limit;
        axis_t home;
        axis_t fault;
        axis_t safety_amp_disable;
        logic  relay;
        logic  mv_good;
        logic  v_fault;
    } board_in_t;

    // amplifier command from a status write
    typedef struct packed {
        logic  strobe;      // one cycle per status write
        axis_t mask;
        axis_t enable;
        logic  pwr_enable;  // power state seen by the write
    } axis_cmd_t;

    typedef enum logic [1:0] {
        mv_off,
        mv_settling,
        mv_ready
    } mv_state_t;

endpackage

/* verilog/io_sync.sv */
// input synchronizer
// two register stages on every asynchronous board input
module io_sync (
    input  logic                  sysclk,
    input  logic                  reset,
    input  board_pkg::axis_t      neg_limit,
    input  board_pkg::axis_t      pos_limit,
    input  board_pkg::axis_t      home,
    input  board_pkg::axis_t      fault,
    input  board_pkg::axis_t      safety_amp_disable,
    input  logic                  relay,
    input  logic                  mv_good,
    input  logic                  v_fault,
    output board_pkg::board_in_t  sync_in
);

    board_pkg::board_in_t raw_in;   // pins gathered into one word
    board_pkg::board_in_t meta;     // first stage, may go metastable

    assign raw_in = '{
        neg_limit:          neg_limit,
        pos_limit:          pos_limit,
        home:               home,
        fault:              fault,
        safety_amp_disable: safety_amp_disable,
        relay:              relay,
        mv_good:            mv_good,
        v_fault:            v_fault
    };

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            meta    <= '0;
            sync_in <= '0;
        end else begin
            meta    <= raw_in;
            sync_in <= meta;     // second stage, safe to use
        end
    end

endmodule

/* verilog/board_regs.sv */
// channel 0 register file
// masked control writes and registered read mux
module board_regs (
    input  logic                    sysclk,
    input  logic                    reset,
    // host bus
    input  board_pkg::reg_addr_t    reg_addr,
    input  board_pkg::reg_data_t    reg_wdata,
    input  logic                    reg_wen,
    output board_pkg::reg_data_t    reg_rdata,
    // read-only sources
    input  board_pkg::board_in_t    sync_in,
    input  logic [3:0]              board_id,     // rotary switch
    input  logic [15:0]             temp_sense,
    input  board_pkg::reg_data_t    prom_status,
    input  board_pkg::reg_data_t    prom_result,
    input  board_pkg::axis_t        reg_disable,
    input  board_pkg::axis_t        amp_disable,
    input  logic                    wdog_timeout,
    input  board_pkg::axis_t        wdog_amp,
    // control outputs
    output logic                    pwr_enable,
    output logic                    relay_on,
    output board_pkg::axis_t        dout,
    output board_pkg::axis_cmd_t    axis_cmd,
    output board_pkg::wdog_period_t wdog_period,
    output logic                    host_write
);

    logic [15:0] phy_ctrl;     // phy request bits
    logic [15:0] phy_data;     // phy register contents
    logic        chan0;        // address hits this block
    logic [3:0]  offs;

    assign chan0      = (reg_addr[7:4] == board_pkg::board_chan);
    assign offs       = reg_addr[3:0];
    assign host_write = reg_wen && chan0;   // restarts watchdog

    // ------------------------------
    // write side
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            pwr_enable  <= 1'b0;             // power off
            relay_on    <= 1'b0;
            dout        <= '0;
            phy_ctrl    <= '0;
            phy_data    <= '0;
            wdog_period <= '1;               // all ones at startup
            axis_cmd    <= '0;
        end else begin
            axis_cmd.strobe <= 1'b0;         // single cycle pulse
            if (host_write) begin
                case (offs)
                    board_pkg::reg_status: begin
                        // bit 19 masks 18, bit 17 masks 16
                        if (reg_wdata[19])
                            pwr_enable <= reg_wdata[18];
                        if (reg_wdata[17])
                            relay_on <= reg_wdata[16];
                        axis_cmd.strobe     <= 1'b1;
                        axis_cmd.mask       <= reg_wdata[11:8];
                        axis_cmd.enable     <= reg_wdata[3:0];
                        axis_cmd.pwr_enable <= pwr_enable;  // state before write
                    end
                    board_pkg::reg_phyctrl: phy_ctrl <= reg_wdata[15:0];
                    board_pkg::reg_phydata: phy_data <= reg_wdata[15:0];
                    board_pkg::reg_timeout: wdog_period <= reg_wdata[15:0];
                    board_pkg::reg_digiout: begin
                        // [11:8] select which of [3:0] land
                        dout <= (reg_wdata[11:8] & reg_wdata[3:0])
                              | (~reg_wdata[11:8] & dout);
                    end
                    default: ;                 // read-only or unmapped
                endcase
            end
        end
    end

    // ------------------------------
    // read side
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            reg_rdata <= '0;
        end else if (!reg_wen) begin
            if (!chan0) begin
                reg_rdata <= '0;               // other channels not here
            end else begin
                case (offs)
                    board_pkg::reg_status: reg_rdata <= {
                        4'(board_pkg::num_axes), board_id,
                        wdog_timeout, 3'd0,
                        sync_in.mv_good, pwr_enable, ~sync_in.relay, relay_on,
                        4'd0, sync_in.fault,
                        sync_in.safety_amp_disable, ~reg_disable};
                    board_pkg::reg_phyctrl:    reg_rdata <= {16'd0, phy_ctrl};
                    board_pkg::reg_phydata:    reg_rdata <= {16'd0, phy_data};
                    board_pkg::reg_timeout:    reg_rdata <= {16'd0, wdog_period};
                    board_pkg::reg_version:    reg_rdata <= board_pkg::board_version;
                    board_pkg::reg_tempsns:    reg_rdata <= {16'd0, temp_sense};
                    board_pkg::reg_digiout:    reg_rdata <= {28'd0, dout};
                    board_pkg::reg_fw_version: reg_rdata <= board_pkg::fw_version;
                    board_pkg::reg_promstat:   reg_rdata <= prom_status;
                    board_pkg::reg_promres:    reg_rdata <= prom_result;
                    board_pkg::reg_digin: reg_rdata <= {
                        15'd0, sync_in.v_fault, dout,
                        sync_in.neg_limit, sync_in.pos_limit, sync_in.home};
                    board_pkg::reg_safety:
                        reg_rdata <= {28'd0, sync_in.safety_amp_disable};
                    board_pkg::reg_wdog:       reg_rdata <= {28'd0, wdog_amp};
                    board_pkg::reg_regdisable: reg_rdata <= {28'd0, amp_disable};
                    default:                   reg_rdata <= '0;
                endcase
            end
        end
    end

endmodule

/* verilog/wdog_timer.sv */
// watchdog and motor-voltage settle timers
// both run off a shared tick prescaled from sysclk
module wdog_timer (
    input  logic                    sysclk,
    input  logic                    reset,
    input  logic                    host_write,
    input  board_pkg::wdog_period_t wdog_period,
    input  logic                    mv_good,      // already synchronized
    output logic                    wdog_timeout,
    output board_pkg::axis_t        wdog_amp,
    output logic                    mv_hold
);

    logic [board_pkg::wdog_prescale_width-1:0] prescale;
    logic                    tick;
    board_pkg::wdog_period_t wdog_count;
    board_pkg::settle_cnt_t  settle_count;
    board_pkg::mv_state_t    mv_state;

    // ------------------------------
    // prescaler, free running
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset)
            prescale <= '0;
        else
            prescale <= prescale + 1'b1;
    end

    assign tick = (prescale == '1);   // every 16 cycles

    // watchdog, any host write restarts it
    always_ff @(posedge sysclk) begin
        if (!reset || host_write) begin
            wdog_count   <= '0;
            wdog_timeout <= 1'b0;
            wdog_amp     <= '0;
        end else if (tick && wdog_period != '0) begin   // zero period = off
            if (wdog_count < wdog_period) begin
                wdog_count <= wdog_count + 1'b1;
            end else begin
                wdog_timeout <= 1'b1;     // sticky until next write
                wdog_amp     <= '1;       // kill every axis
            end
        end
    end

    // ------------------------------
    // motor voltage settle FSM
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            mv_state     <= board_pkg::mv_off;
            settle_count <= '0;
        end else if (!mv_good) begin
            mv_state     <= board_pkg::mv_off;   // drop out at once
            settle_count <= '0;
        end else begin
            case (mv_state)
                board_pkg::mv_off: mv_state <= board_pkg::mv_settling;
                board_pkg::mv_settling: begin
                    if (tick) begin
                        if (settle_count == board_pkg::mv_settle_ticks)
                            mv_state <= board_pkg::mv_ready;
                        else
                            settle_count <= settle_count + 1'b1;
                    end
                end
                default: ;                      // ready, hold here
            endcase
        end
    end

    assign mv_hold = (mv_state != board_pkg::mv_ready);

endmodule

/* verilog/amp_safety.sv */
// amplifier disable latch
// host commands and watchdog set it, settle hold overrides the output
module amp_safety (
    input  logic                 sysclk,
    input  logic                 reset,
    input  board_pkg::axis_cmd_t axis_cmd,
    input  board_pkg::axis_t     wdog_amp,
    input  logic                 mv_hold,
    output board_pkg::axis_t     reg_disable,
    output board_pkg::axis_t     amp_disable
);

    board_pkg::axis_t cmd_next;   // latch value after a command

    // power off disables all, else masked bits take ~enable
    assign cmd_next = {board_pkg::num_axes{~axis_cmd.pwr_enable}}
                    | (axis_cmd.mask & ~axis_cmd.enable)
                    | (~axis_cmd.mask & reg_disable);

    always_ff @(posedge sysclk) begin
        if (!reset)
            reg_disable <= '1;                     // all axes off
        else if (axis_cmd.strobe)
            reg_disable <= cmd_next;
        else
            reg_disable <= reg_disable | wdog_amp; // timeout stays latched
    end

    // settle hold forces every axis off
    assign amp_disable = reg_disable | {board_pkg::num_axes{mv_hold}};

endmodule

/* verilog/qla_board_top.sv */
// board control top level
// synchronizer, registers, timers and safety latch in a chain
module qla_board_top (
    input  logic                 sysclk,
    input  logic                 reset,
    // board inputs
    input  board_pkg::axis_t     neg_limit,
    input  board_pkg::axis_t     pos_limit,
    input  board_pkg::axis_t     home,
    input  board_pkg::axis_t     fault,
    input  board_pkg::axis_t     safety_amp_disable,
    input  logic                 relay,
    input  logic                 mv_good,
    input  logic                 v_fault,
    input  logic [3:0]           board_id,
    input  logic [15:0]          temp_sense,
    // host bus
    input  board_pkg::reg_addr_t reg_addr,
    input  board_pkg::reg_data_t reg_wdata,
    input  logic                 reg_wen,
    output board_pkg::reg_data_t reg_rdata,
    // prom feedback
    input  board_pkg::reg_data_t prom_status,
    input  board_pkg::reg_data_t prom_result,
    // board outputs
    output board_pkg::axis_t     amp_disable,
    output board_pkg::axis_t     dout,
    output logic                 pwr_enable,
    output logic                 relay_on
);

    board_pkg::board_in_t    sync_in;
    board_pkg::axis_cmd_t    axis_cmd;
    board_pkg::wdog_period_t wdog_period;
    board_pkg::axis_t        wdog_amp;
    board_pkg::axis_t        reg_disable;
    logic                    host_write;
    logic                    wdog_timeout;
    logic                    mv_hold;

    io_sync u_sync (
        .sysclk(sysclk), .reset(reset),
        .neg_limit(neg_limit), .pos_limit(pos_limit), .home(home),
        .fault(fault), .safety_amp_disable(safety_amp_disable),
        .relay(relay), .mv_good(mv_good), .v_fault(v_fault),
        .sync_in(sync_in)
    );

    board_regs u_regs (
        .sysclk(sysclk), .reset(reset),
        .reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_wen(reg_wen),
        .reg_rdata(reg_rdata), .sync_in(sync_in),
        .board_id(board_id), .temp_sense(temp_sense),
        .prom_status(prom_status), .prom_result(prom_result),
        .reg_disable(reg_disable), .amp_disable(amp_disable),
        .wdog_timeout(wdog_timeout), .wdog_amp(wdog_amp),
        .pwr_enable(pwr_enable), .relay_on(relay_on), .dout(dout),
        .axis_cmd(axis_cmd), .wdog_period(wdog_period), .host_write(host_write)
    );

    wdog_timer u_wdog (
        .sysclk(sysclk), .reset(reset),
        .host_write(host_write), .wdog_period(wdog_period),
        .mv_good(sync_in.mv_good),           // synchronized copy
        .wdog_timeout(wdog_timeout), .wdog_amp(wdog_amp), .mv_hold(mv_hold)
    );

    amp_safety u_safety (
        .sysclk(sysclk), .reset(reset),
        .axis_cmd(axis_cmd), .wdog_amp(wdog_amp), .mv_hold(mv_hold),
        .reg_disable(reg_disable), .amp_disable(amp_disable)
    );

endmodule

/* verification/board_asserts.sv */
// safety assertions bound into the board top level
// pins must never show less disable than the latch or the settle hold
module board_asserts (
    input logic             sysclk,
    input logic             reset,
    input board_pkg::axis_t amp_disable,
    input board_pkg::axis_t reg_disable,
    input logic             mv_hold
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;     // summed into the final result

    // every latched disable bit reaches the amplifier pins
    latch_covered: assert property (@(posedge sysclk) disable iff (!reset)
        (amp_disable & reg_disable) == reg_disable)
        else begin
            fail_count++;
            $error("amp_disable lost a latched disable bit");
        end

    // settle hold kills all axes
    hold_forces_off: assert property (@(posedge sysclk) disable iff (!reset)
        mv_hold |-> (amp_disable == '1))
        else begin
            fail_count++;
            $error("amp_disable not all ones during settle hold");
        end

endmodule

bind qla_board_top board_asserts u_asserts (
    .sysclk(sysclk), .reset(reset), .amp_disable(amp_disable),
    .reg_disable(reg_disable), .mv_hold(mv_hold)
);

/* verification/board_checker.sv */
// output and read data checker
// compares DUT ports with model values on flagged clock edges
module board_checker (
    input  logic                 clk,
    input  logic                 chk_out,       // compare output pins this edge
    input  logic                 chk_rd,        // compare read data this edge
    input  board_pkg::axis_t     amp_disable,
    input  board_pkg::axis_t     dout,
    input  logic                 pwr_enable,
    input  logic                 relay_on,
    input  board_pkg::reg_data_t reg_rdata,
    input  board_pkg::axis_t     exp_amp,
    input  board_pkg::axis_t     exp_dout,
    input  logic                 exp_pwr,
    input  logic                 exp_relay,
    input  board_pkg::reg_data_t exp_rdata,
    output int                   err_count,
    output int                   check_count
);
    timeunit 1ns;
    timeprecision 100ps;

    int test_errs0 = 0;     // totals when the current test began
    int test_chks0 = 0;

    initial begin
        err_count   = 0;
        check_count = 0;
    end

    task automatic compare(input string what, input logic [31:0] got,
                           input logic [31:0] exp);
        check_count = check_count + 1;
        if (got !== exp) begin
            err_count = err_count + 1;
            $display("ERR t=%0t %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // ------------------------------
    // outputs settled since last posedge, model set at negedge
    always @(posedge clk) begin
        if (chk_out) begin
            compare("amp_disable", 32'(amp_disable), 32'(exp_amp));
            compare("dout", 32'(dout), 32'(exp_dout));
            compare("pwr_enable", 32'(pwr_enable), 32'(exp_pwr));
            compare("relay_on", 32'(relay_on), 32'(exp_relay));
        end
        if (chk_rd)
            compare("reg_rdata", reg_rdata, exp_rdata);
    end

    // one summary line per finished test
    task automatic report_test(input string name);
        int errs;
        errs = err_count - test_errs0;
        $display("test %-14s %5d checks %4d errors  %s", name,
                 check_count - test_chks0, errs, (errs == 0) ? "ok" : "failed");
        test_errs0 = err_count;
        test_chks0 = check_count;
    endtask

endmodule

/* verification/tb_qla_board.sv */
// testbench for the board control block
// seeded random host traffic checked against a reference model
module tb_qla_board;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_writes   = 200;
    localparam int n_rand_rd  = 50;
    // settle wait, 3 cycles per write, 5 per read, timer tests
    localparam int run_cycles = 4 + 200 + 3 * (n_writes + 10) + 5 * (14 + n_rand_rd) + 400;
    localparam int cycle_limit = 10 * run_cycles;

    logic                 sysclk, reset, relay, mv_good, v_fault, reg_wen;
    board_pkg::axis_t     neg_limit, pos_limit, home, fault, safety_amp_disable;
    board_pkg::axis_t     amp_disable, dout;
    logic                 pwr_enable, relay_on;
    logic [3:0]           board_id;
    logic [15:0]          temp_sense;
    board_pkg::reg_addr_t reg_addr;
    board_pkg::reg_data_t reg_wdata, reg_rdata, prom_status, prom_result;

    // reference model
    logic                    m_pwr, m_relay, m_hold, m_wdog_fired;
    board_pkg::axis_t        m_dout, m_reg_dis;
    logic [15:0]             m_phy_ctrl, m_phy_data;
    board_pkg::wdog_period_t m_period;
    int                      m_write_cycle, m_mv_rise_cycle;

    logic                 chk_out, chk_rd, exp_pwr, exp_relay;
    board_pkg::axis_t     exp_amp, exp_dout;
    board_pkg::reg_data_t exp_rdata;
    int                   err_count, check_count;
    int                   cycle = 0;
    integer               seed = 61;
    logic [3:0]           mapped [14] = '{0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 14, 15};

    qla_board_top uut (.*);

    board_checker chk (
        .clk(sysclk), .chk_out, .chk_rd, .amp_disable, .dout, .pwr_enable,
        .relay_on, .reg_rdata, .exp_amp, .exp_dout, .exp_pwr, .exp_relay,
        .exp_rdata, .err_count, .check_count
    );

    initial begin
        sysclk = 1'b0;
        forever #5 sysclk = ~sysclk;
    end

    always @(posedge sysclk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic step();
        @(negedge sysclk);
        chk_out = 1'b0;
        chk_rd  = 1'b0;
    endtask

    task automatic expect_outputs();
        exp_amp   = m_reg_dis | {4{m_hold}};   // hold forces all axes
        exp_dout  = m_dout;
        exp_pwr   = m_pwr;
        exp_relay = m_relay;
        chk_out   = 1'b1;
    endtask

    function automatic board_pkg::reg_data_t expected_read(input board_pkg::reg_addr_t addr);
        board_pkg::reg_data_t v;
        v = '0;
        if (addr[7:4] == 4'd0) begin        // only channel 0 answers
            case (addr[3:0])
                4'd0: v = {4'd4, board_id, m_wdog_fired, 3'd0, mv_good, m_pwr, ~relay,
                           m_relay, 4'd0, fault, safety_amp_disable, ~m_reg_dis};
                4'd1: v = {16'd0, m_phy_ctrl};
                4'd2: v = {16'd0, m_phy_data};
                4'd3: v = {16'd0, m_period};
                4'd4: v = 32'h5445_5354;        // "TEST"
                4'd5: v = {16'd0, temp_sense};
                4'd6: v = {28'd0, m_dout};
                4'd7: v = 32'd3;
                4'd8: v = prom_status;
                4'd9: v = prom_result;
                4'd10: v = {15'd0, v_fault, m_dout, neg_limit, pos_limit, home};
                4'd11: v = {28'd0, safety_amp_disable};
                4'd14: v = {28'd0, {4{m_wdog_fired}}};
                4'd15: v = {28'd0, m_reg_dis | {4{m_hold}}};
                default: v = '0;
            endcase
        end
        return v;
    endfunction

    // write at this negedge, outputs checked on the next two cycles
    task automatic write_reg(input logic [3:0] offs, input board_pkg::reg_data_t d);
        logic old_pwr;
        reg_addr  = {4'd0, offs};
        reg_wdata = d;
        reg_wen   = 1'b1;
        step();
        reg_wen       = 1'b0;
        m_wdog_fired  = 1'b0;              // any write restarts the watchdog
        m_write_cycle = cycle;
        old_pwr       = m_pwr;
        case (offs)
            4'd0: begin
                if (d[19]) m_pwr = d[18];
                if (d[17]) m_relay = d[16];
            end
            4'd1: m_phy_ctrl = d[15:0];
            4'd2: m_phy_data = d[15:0];
            4'd3: m_period = d[15:0];
            4'd6: m_dout = (d[11:8] & d[3:0]) | (~d[11:8] & m_dout);
            default: ;
        endcase
        expect_outputs();                  // amp_disable not moved yet
        step();
        if (offs == 4'd0)
            m_reg_dis = old_pwr ? ((d[11:8] & ~d[3:0]) | (~d[11:8] & m_reg_dis)) : '1;
        expect_outputs();
        step();
    endtask

    task automatic read_check(input board_pkg::reg_addr_t addr);
        reg_addr = addr;
        step();
        exp_rdata = expected_read(addr);
        chk_rd    = 1'b1;
        step();
    endtask

    task automatic randomize_inputs();
        neg_limit          = 4'($random(seed));
        pos_limit          = 4'($random(seed));
        home               = 4'($random(seed));
        fault              = 4'($random(seed));
        safety_amp_disable = 4'($random(seed));
        relay              = 1'($random(seed));
        v_fault            = 1'($random(seed));
        board_id           = 4'($random(seed));
        temp_sense         = 16'($random(seed));
        prom_status        = $random(seed);
        prom_result        = $random(seed);
    endtask

    initial begin
        reset = 1'b0;
        reg_wen = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        mv_good = 1'b1;
        chk_out = 1'b0;
        chk_rd = 1'b0;
        randomize_inputs();
        {m_pwr, m_relay, m_wdog_fired, m_dout, m_phy_ctrl, m_phy_data} = '0;
        m_hold = 1'b1;
        m_reg_dis = '1;
        m_period = '1;
        repeat (4) @(negedge sysclk);      // 4 cycles in reset
        reset = 1'b1;

        // ---------- reset state ----------
        expect_outputs();
        step();
        read_check(8'd3);
        read_check(8'd4);
        read_check(8'd7);
        chk.report_test("reset");

        // ---------- masked writes ----------
        repeat (200) step();               // let motor voltage settle
        m_hold = 1'b0;
        expect_outputs();
        step();
        for (int i = 0; i < n_writes; i++)
            write_reg(($random(seed) & 1) ? 4'd0 : 4'd6, $random(seed));
        chk.report_test("masked_writes");

        // ---------- register reads ----------
        write_reg(4'd1, $random(seed));
        write_reg(4'd2, $random(seed));
        for (int i = 0; i < 14 + n_rand_rd; i++) begin
            randomize_inputs();
            repeat (3) step();             // through sync stages
            read_check((i < 14) ? {4'd0, mapped[i]} : 8'($random(seed)));
        end
        chk.report_test("reads");

        // ---------- watchdog ----------
        write_reg(4'd3, 32'd4);
        while (cycle - m_write_cycle < 61) step();
        read_check(8'd0);                  // not expired yet
        while (cycle - m_write_cycle < 84) step();
        m_wdog_fired = 1'b1;
        m_reg_dis = '1;
        expect_outputs();
        step();
        read_check(8'd0);
        read_check(8'd14);
        write_reg(4'd2, $random(seed));    // clears the flag only
        read_check(8'd0);
        write_reg(4'd0, 32'h000C_0F0F);
        write_reg(4'd0, 32'h000C_0F0F);    // power now on, axes enable
        write_reg(4'd3, 32'd0);            // watchdog off
        chk.report_test("watchdog");

        // ---------- motor voltage ----------
        mv_good = 1'b0;
        repeat (3) step();
        m_hold = 1'b1;
        expect_outputs();
        repeat (10) step();
        mv_good = 1'b1;
        m_mv_rise_cycle = cycle;
        while (cycle - m_mv_rise_cycle < 128) step();
        expect_outputs();                  // still settling
        while (cycle - m_mv_rise_cycle < 147) step();
        m_hold = 1'b0;
        expect_outputs();
        step();
        chk.report_test("motor_voltage");

        $display("checks %0d errors %0d assertion failures %0d",
                 check_count, err_count, uut.u_asserts.fail_count);
        if (err_count == 0 && uut.u_asserts.fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* qla_board.f */
verilog/board_pkg.sv
verilog/io_sync.sv
verilog/board_regs.sv
verilog/wdog_timer.sv
verilog/amp_safety.sv
verilog/qla_board_top.sv
verification/board_asserts.sv
verification/board_checker.sv
verification/tb_qla_board.sv

/* Makefile */
# Verilator build for the board control block testbench

TOOL     = verilator
FLAGS    = --timing --assert -Wno-fatal
TOP      = tb_qla_board
FILELIST = qla_board.f
OBJ_DIR  = obj_dir
LOG      = sim.log
SIM_ARGS = +verilator+error+limit+100
FAIL_MSG = === FAIL ===

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
